// File: Bender.yml
package:
  name: dual_issue_core

sources:
  - dispatch_pkg.sv
  - regfile.sv
  - csr_bank.sv
  - dispatch.sv
  - exec_stage.sv
  - dual_issue_core.sv
  - target: simulation
    files:
      - dual_issue_sva.sv
      - tb_dual_issue.sv

// File: all.f
dispatch_pkg.sv
regfile.sv
csr_bank.sv
dispatch.sv
exec_stage.sv
dual_issue_core.sv
dual_issue_sva.sv
tb_dual_issue.sv

// File: csr_bank.sv
module csr_bank (
    input  logic clk,
    input  logic rst_n,

    // Read port, used by dispatch
    input  logic [dispatch_pkg::CSR_ADDR_W-1:0] raddr_i,
    output logic [dispatch_pkg::XLEN-1:0]       rdata_o,

    // Write port, driven from the execute stage
    input  logic                                we_i,
    input  logic [dispatch_pkg::CSR_ADDR_W-1:0] waddr_i,
    input  logic [dispatch_pkg::XLEN-1:0]       wdata_i
);
    import dispatch_pkg::*;

    logic [XLEN-1:0] csrs [NUM_CSR];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_CSR; i++) begin
                csrs[i] <= '0;
            end
        end else if (we_i) begin
            csrs[waddr_i] <= wdata_i;
        end
    end

    // Bypass the pending write so a read right behind a write sees the new value
    always_comb begin
        if (we_i && waddr_i == raddr_i) begin
            rdata_o = wdata_i;
        end else begin
            rdata_o = csrs[raddr_i];
        end
    end

endmodule

// File: dispatch.sv
module dispatch (
    input  logic clk,
    input  logic rst_n,
    input  logic flush_i,

    // Instruction buffer slots
    input  logic [dispatch_pkg::ISSUE_WIDTH-1:0]                               instr_valid_i,
    input  dispatch_pkg::op_e [dispatch_pkg::ISSUE_WIDTH-1:0]                  instr_op_i,
    input  logic [dispatch_pkg::ISSUE_WIDTH-1:0][dispatch_pkg::REG_ADDR_W-1:0] instr_rd_i,
    input  logic [dispatch_pkg::ISSUE_WIDTH-1:0][dispatch_pkg::REG_ADDR_W-1:0] instr_rs1_i,
    input  logic [dispatch_pkg::ISSUE_WIDTH-1:0][dispatch_pkg::REG_ADDR_W-1:0] instr_rs2_i,
    input  logic [dispatch_pkg::ISSUE_WIDTH-1:0]                               instr_use_imm_i,
    input  logic [dispatch_pkg::ISSUE_WIDTH-1:0][dispatch_pkg::XLEN-1:0]       instr_imm_i,
    output logic [dispatch_pkg::ISSUE_WIDTH-1:0]                               ib_accept_o,

    // Register file
    output logic [2*dispatch_pkg::ISSUE_WIDTH-1:0][dispatch_pkg::REG_ADDR_W-1:0] rf_raddr_o,
    input  logic [2*dispatch_pkg::ISSUE_WIDTH-1:0][dispatch_pkg::XLEN-1:0]       rf_rdata_i,

    // CSR bank
    output logic [dispatch_pkg::CSR_ADDR_W-1:0] csr_raddr_o,
    input  logic [dispatch_pkg::XLEN-1:0]       csr_rdata_i,

    // Forwarding from execute and writeback
    input  logic [dispatch_pkg::ISSUE_WIDTH-1:0]                               ex_fwd_we_i,
    input  logic [dispatch_pkg::ISSUE_WIDTH-1:0][dispatch_pkg::REG_ADDR_W-1:0] ex_fwd_rd_i,
    input  logic [dispatch_pkg::ISSUE_WIDTH-1:0][dispatch_pkg::XLEN-1:0]       ex_fwd_data_i,
    input  logic [dispatch_pkg::ISSUE_WIDTH-1:0]                               wb_fwd_we_i,
    input  logic [dispatch_pkg::ISSUE_WIDTH-1:0][dispatch_pkg::REG_ADDR_W-1:0] wb_fwd_rd_i,
    input  logic [dispatch_pkg::ISSUE_WIDTH-1:0][dispatch_pkg::XLEN-1:0]       wb_fwd_data_i,

    // Issue register toward execute
    output logic [dispatch_pkg::ISSUE_WIDTH-1:0]                               iss_valid_o,
    output dispatch_pkg::op_e [dispatch_pkg::ISSUE_WIDTH-1:0]                  iss_op_o,
    output logic [dispatch_pkg::ISSUE_WIDTH-1:0][dispatch_pkg::REG_ADDR_W-1:0] iss_rd_o,
    output logic [dispatch_pkg::ISSUE_WIDTH-1:0][dispatch_pkg::XLEN-1:0]       iss_opa_o,
    output logic [dispatch_pkg::ISSUE_WIDTH-1:0][dispatch_pkg::XLEN-1:0]       iss_opb_o,
    output logic [dispatch_pkg::CSR_ADDR_W-1:0]                                iss_csr_addr_o,
    output logic [dispatch_pkg::XLEN-1:0]                                      iss_csr_data_o
);
    import dispatch_pkg::*;

    logic                                   slot0_writes;
    logic                                   slot1_raw;
    logic                                   csr_any;
    logic [ISSUE_WIDTH-1:0]                 issue_mask;
    logic [2*ISSUE_WIDTH-1:0][XLEN-1:0]     fwd_data;

    // Younger slot reading what the older slot writes
    assign slot0_writes = instr_valid_i[0] && writes_rd(instr_op_i[0]) && instr_rd_i[0] != '0;
    assign slot1_raw    = slot0_writes &&
                          (instr_rs1_i[1] == instr_rd_i[0] ||
                           (!instr_use_imm_i[1] && instr_rs2_i[1] == instr_rd_i[0]));

    assign csr_any = (instr_valid_i[0] && is_csr_op(instr_op_i[0])) ||
                     (instr_valid_i[1] && is_csr_op(instr_op_i[1]));

    always_comb begin
        if (flush_i) begin
            issue_mask = 2'b00;
        end else if (slot1_raw) begin
            issue_mask = 2'b01;
        end else if (csr_any) begin
            issue_mask = 2'b01;
        end else begin
            issue_mask = 2'b11;
        end
    end

    // In-order: slot 1 only goes together with slot 0
    assign ib_accept_o[0] = issue_mask[0] && instr_valid_i[0];
    assign ib_accept_o[1] = issue_mask[1] && instr_valid_i[1] && instr_valid_i[0];

    always_comb begin
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            rf_raddr_o[2*s]   = instr_rs1_i[s];
            rf_raddr_o[2*s+1] = instr_rs2_i[s];
        end
    end

    // First CSR instruction among the slots picks the read address
    always_comb begin
        csr_raddr_o = '0;
        for (int s = ISSUE_WIDTH - 1; s >= 0; s--) begin
            if (is_csr_op(instr_op_i[s])) begin
                csr_raddr_o = instr_imm_i[s][CSR_ADDR_W-1:0];
            end
        end
    end

    // Forwarding, later assignments win: ex1, ex0, wb1, wb0, then regfile
    always_comb begin
        for (int p = 0; p < 2*ISSUE_WIDTH; p++) begin
            fwd_data[p] = rf_rdata_i[p];
            for (int w = 0; w < ISSUE_WIDTH; w++) begin
                if (wb_fwd_we_i[w] && wb_fwd_rd_i[w] == rf_raddr_o[p] && rf_raddr_o[p] != '0) begin
                    fwd_data[p] = wb_fwd_data_i[w];
                end
            end
            for (int w = 0; w < ISSUE_WIDTH; w++) begin
                if (ex_fwd_we_i[w] && ex_fwd_rd_i[w] == rf_raddr_o[p] && rf_raddr_o[p] != '0) begin
                    fwd_data[p] = ex_fwd_data_i[w];
                end
            end
        end
    end

    // Issue register, flush lands here through a zero accept mask
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            iss_valid_o    <= '0;
            iss_rd_o       <= '0;
            iss_opa_o      <= '0;
            iss_opb_o      <= '0;
            iss_csr_addr_o <= '0;
            iss_csr_data_o <= '0;
            for (int s = 0; s < ISSUE_WIDTH; s++) begin
                iss_op_o[s] <= OP_NOP;
            end
        end else begin
            for (int s = 0; s < ISSUE_WIDTH; s++) begin
                if (ib_accept_o[s]) begin
                    iss_valid_o[s] <= 1'b1;
                    iss_op_o[s]    <= instr_op_i[s];
                    iss_rd_o[s]    <= instr_rd_i[s];
                    iss_opa_o[s]   <= fwd_data[2*s];
                    iss_opb_o[s]   <= instr_use_imm_i[s] ? instr_imm_i[s] : fwd_data[2*s+1];
                end else begin
                    iss_valid_o[s] <= 1'b0;
                    iss_op_o[s]    <= OP_NOP;
                    iss_rd_o[s]    <= '0;
                    iss_opa_o[s]   <= '0;
                    iss_opb_o[s]   <= '0;
                end
            end
            // A CSR op only ever issues in slot 0
            if (ib_accept_o[0]) begin
                iss_csr_addr_o <= csr_raddr_o;
                iss_csr_data_o <= csr_rdata_i;
            end else begin
                iss_csr_addr_o <= '0;
                iss_csr_data_o <= '0;
            end
        end
    end

endmodule

// File: dispatch_pkg.sv
package dispatch_pkg;

    // Two instruction slots, slot 0 is always the older one
    localparam int ISSUE_WIDTH = 2;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // CSR address comes from the low immediate bits
    localparam int CSR_ADDR_W = 2;
    localparam int NUM_CSR    = 4;

    // CSR map
    localparam logic [CSR_ADDR_W-1:0] CSR_CTRL     = 2'd0;
    localparam logic [CSR_ADDR_W-1:0] CSR_STATUS   = 2'd1;
    localparam logic [CSR_ADDR_W-1:0] CSR_SCRATCH0 = 2'd2;
    localparam logic [CSR_ADDR_W-1:0] CSR_SCRATCH1 = 2'd3;

    typedef enum logic [3:0] {
        OP_NOP   = 4'd0,
        OP_ADD   = 4'd1,
        OP_SUB   = 4'd2,
        OP_AND   = 4'd3,
        OP_OR    = 4'd4,
        OP_XOR   = 4'd5,
        OP_SLL   = 4'd6,
        OP_CSRRD = 4'd7,
        OP_CSRWR = 4'd8
    } op_e;

    // CSR accesses always issue alone
    function automatic logic is_csr_op(op_e op);
        return (op == OP_CSRRD) || (op == OP_CSRWR);
    endfunction

    // Every opcode except NOP produces a result for rd
    function automatic logic writes_rd(op_e op);
        return op != OP_NOP;
    endfunction

endpackage

// File: dual_issue_core.sv
module dual_issue_core (
    input  logic clk,
    input  logic rst_n,
    input  logic flush_i,

    input  logic [dispatch_pkg::ISSUE_WIDTH-1:0]                               instr_valid_i,
    input  dispatch_pkg::op_e [dispatch_pkg::ISSUE_WIDTH-1:0]                  instr_op_i,
    input  logic [dispatch_pkg::ISSUE_WIDTH-1:0][dispatch_pkg::REG_ADDR_W-1:0] instr_rd_i,
    input  logic [dispatch_pkg::ISSUE_WIDTH-1:0][dispatch_pkg::REG_ADDR_W-1:0] instr_rs1_i,
    input  logic [dispatch_pkg::ISSUE_WIDTH-1:0][dispatch_pkg::REG_ADDR_W-1:0] instr_rs2_i,
    input  logic [dispatch_pkg::ISSUE_WIDTH-1:0]                               instr_use_imm_i,
    input  logic [dispatch_pkg::ISSUE_WIDTH-1:0][dispatch_pkg::XLEN-1:0]       instr_imm_i,
    output logic [dispatch_pkg::ISSUE_WIDTH-1:0]                               ib_accept_o,

    output logic [dispatch_pkg::ISSUE_WIDTH-1:0]                               wb_valid_o,
    output logic [dispatch_pkg::ISSUE_WIDTH-1:0][dispatch_pkg::REG_ADDR_W-1:0] wb_rd_o,
    output logic [dispatch_pkg::ISSUE_WIDTH-1:0][dispatch_pkg::XLEN-1:0]       wb_data_o
);
    import dispatch_pkg::*;

    logic [2*ISSUE_WIDTH-1:0][REG_ADDR_W-1:0] rf_raddr;
    logic [2*ISSUE_WIDTH-1:0][XLEN-1:0]       rf_rdata;

    logic [CSR_ADDR_W-1:0] csr_raddr;
    logic [XLEN-1:0]       csr_rdata;
    logic                  csr_we;
    logic [CSR_ADDR_W-1:0] csr_waddr;
    logic [XLEN-1:0]       csr_wdata;

    logic [ISSUE_WIDTH-1:0]                 iss_valid;
    op_e  [ISSUE_WIDTH-1:0]                 iss_op;
    logic [ISSUE_WIDTH-1:0][REG_ADDR_W-1:0] iss_rd;
    logic [ISSUE_WIDTH-1:0][XLEN-1:0]       iss_opa;
    logic [ISSUE_WIDTH-1:0][XLEN-1:0]       iss_opb;
    logic [CSR_ADDR_W-1:0]                  iss_csr_addr;
    logic [XLEN-1:0]                        iss_csr_data;

    logic [ISSUE_WIDTH-1:0]                 ex_fwd_we;
    logic [ISSUE_WIDTH-1:0][REG_ADDR_W-1:0] ex_fwd_rd;
    logic [ISSUE_WIDTH-1:0][XLEN-1:0]       ex_fwd_data;

    dispatch u_dispatch (
        .clk             (clk),
        .rst_n           (rst_n),
        .flush_i         (flush_i),
        .instr_valid_i   (instr_valid_i),
        .instr_op_i      (instr_op_i),
        .instr_rd_i      (instr_rd_i),
        .instr_rs1_i     (instr_rs1_i),
        .instr_rs2_i     (instr_rs2_i),
        .instr_use_imm_i (instr_use_imm_i),
        .instr_imm_i     (instr_imm_i),
        .ib_accept_o     (ib_accept_o),
        .rf_raddr_o      (rf_raddr),
        .rf_rdata_i      (rf_rdata),
        .csr_raddr_o     (csr_raddr),
        .csr_rdata_i     (csr_rdata),
        .ex_fwd_we_i     (ex_fwd_we),
        .ex_fwd_rd_i     (ex_fwd_rd),
        .ex_fwd_data_i   (ex_fwd_data),
        .wb_fwd_we_i     (wb_valid_o),
        .wb_fwd_rd_i     (wb_rd_o),
        .wb_fwd_data_i   (wb_data_o),
        .iss_valid_o     (iss_valid),
        .iss_op_o        (iss_op),
        .iss_rd_o        (iss_rd),
        .iss_opa_o       (iss_opa),
        .iss_opb_o       (iss_opb),
        .iss_csr_addr_o  (iss_csr_addr),
        .iss_csr_data_o  (iss_csr_data)
    );

    // Writeback register drives the write ports directly
    regfile u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .raddr_i (rf_raddr),
        .rdata_o (rf_rdata),
        .we_i    (wb_valid_o),
        .waddr_i (wb_rd_o),
        .wdata_i (wb_data_o)
    );

    csr_bank u_csr_bank (
        .clk     (clk),
        .rst_n   (rst_n),
        .raddr_i (csr_raddr),
        .rdata_o (csr_rdata),
        .we_i    (csr_we),
        .waddr_i (csr_waddr),
        .wdata_i (csr_wdata)
    );

    exec_stage u_exec_stage (
        .clk            (clk),
        .rst_n          (rst_n),
        .iss_valid_i    (iss_valid),
        .iss_op_i       (iss_op),
        .iss_rd_i       (iss_rd),
        .iss_opa_i      (iss_opa),
        .iss_opb_i      (iss_opb),
        .iss_csr_addr_i (iss_csr_addr),
        .iss_csr_data_i (iss_csr_data),
        .ex_fwd_we_o    (ex_fwd_we),
        .ex_fwd_rd_o    (ex_fwd_rd),
        .ex_fwd_data_o  (ex_fwd_data),
        .csr_we_o       (csr_we),
        .csr_waddr_o    (csr_waddr),
        .csr_wdata_o    (csr_wdata),
        .wb_we_o        (wb_valid_o),
        .wb_rd_o        (wb_rd_o),
        .wb_data_o      (wb_data_o)
    );

endmodule

// File: dual_issue_sva.sv
module dual_issue_sva (
    input logic                                               clk,
    input logic                                               rst_n,
    input logic [dispatch_pkg::ISSUE_WIDTH-1:0]               instr_valid_i,
    input dispatch_pkg::op_e [dispatch_pkg::ISSUE_WIDTH-1:0]  instr_op_i,
    input logic [dispatch_pkg::ISSUE_WIDTH-1:0]               ib_accept_o,
    input logic [dispatch_pkg::ISSUE_WIDTH-1:0]               wb_valid_o
);
    import dispatch_pkg::*;

    logic csr_present;

    assign csr_present = (instr_valid_i[0] && is_csr_op(instr_op_i[0])) ||
                         (instr_valid_i[1] && is_csr_op(instr_op_i[1]));

    // In-order acceptance
    a_accept_order: assert property (@(posedge clk) disable iff (!rst_n)
        ib_accept_o[1] |-> ib_accept_o[0])
        else $error("slot 1 accepted without slot 0");

    a_csr_alone: assert property (@(posedge clk) disable iff (!rst_n)
        csr_present |-> ib_accept_o != 2'b11)
        else $error("CSR instruction accepted as part of a pair");

    // Nothing can reach writeback this early
    a_wb_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> (wb_valid_o == '0) ##1 (wb_valid_o == '0))
        else $error("writeback valid too soon after reset");

endmodule

bind dual_issue_core dual_issue_sva u_dual_issue_sva (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_valid_i (instr_valid_i),
    .instr_op_i    (instr_op_i),
    .ib_accept_o   (ib_accept_o),
    .wb_valid_o    (wb_valid_o)
);

// File: exec_stage.sv
module exec_stage (
    input  logic clk,
    input  logic rst_n,

    // From the dispatch issue register
    input  logic [dispatch_pkg::ISSUE_WIDTH-1:0]                               iss_valid_i,
    input  dispatch_pkg::op_e [dispatch_pkg::ISSUE_WIDTH-1:0]                  iss_op_i,
    input  logic [dispatch_pkg::ISSUE_WIDTH-1:0][dispatch_pkg::REG_ADDR_W-1:0] iss_rd_i,
    input  logic [dispatch_pkg::ISSUE_WIDTH-1:0][dispatch_pkg::XLEN-1:0]       iss_opa_i,
    input  logic [dispatch_pkg::ISSUE_WIDTH-1:0][dispatch_pkg::XLEN-1:0]       iss_opb_i,
    input  logic [dispatch_pkg::CSR_ADDR_W-1:0]                                iss_csr_addr_i,
    input  logic [dispatch_pkg::XLEN-1:0]                                      iss_csr_data_i,

    // Execute-stage forwarding
    output logic [dispatch_pkg::ISSUE_WIDTH-1:0]                               ex_fwd_we_o,
    output logic [dispatch_pkg::ISSUE_WIDTH-1:0][dispatch_pkg::REG_ADDR_W-1:0] ex_fwd_rd_o,
    output logic [dispatch_pkg::ISSUE_WIDTH-1:0][dispatch_pkg::XLEN-1:0]       ex_fwd_data_o,

    // CSR write in the execute cycle
    output logic                                                               csr_we_o,
    output logic [dispatch_pkg::CSR_ADDR_W-1:0]                                csr_waddr_o,
    output logic [dispatch_pkg::XLEN-1:0]                                      csr_wdata_o,

    // Writeback register
    output logic [dispatch_pkg::ISSUE_WIDTH-1:0]                               wb_we_o,
    output logic [dispatch_pkg::ISSUE_WIDTH-1:0][dispatch_pkg::REG_ADDR_W-1:0] wb_rd_o,
    output logic [dispatch_pkg::ISSUE_WIDTH-1:0][dispatch_pkg::XLEN-1:0]       wb_data_o
);
    import dispatch_pkg::*;

    // One ALU per slot
    always_comb begin
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            case (iss_op_i[s])
                OP_ADD:   ex_fwd_data_o[s] = iss_opa_i[s] + iss_opb_i[s];
                OP_SUB:   ex_fwd_data_o[s] = iss_opa_i[s] - iss_opb_i[s];
                OP_AND:   ex_fwd_data_o[s] = iss_opa_i[s] & iss_opb_i[s];
                OP_OR:    ex_fwd_data_o[s] = iss_opa_i[s] | iss_opb_i[s];
                OP_XOR:   ex_fwd_data_o[s] = iss_opa_i[s] ^ iss_opb_i[s];
                OP_SLL:   ex_fwd_data_o[s] = iss_opa_i[s] << iss_opb_i[s][4:0];
                // rd gets the value read at dispatch, old value for a write
                OP_CSRRD,
                OP_CSRWR: ex_fwd_data_o[s] = iss_csr_data_i;
                default:  ex_fwd_data_o[s] = '0;
            endcase
            ex_fwd_we_o[s] = iss_valid_i[s] && writes_rd(iss_op_i[s]) && iss_rd_i[s] != '0;
        end
    end

    assign ex_fwd_rd_o = iss_rd_i;

    // CSR write takes operand A, even with rd zero
    always_comb begin
        csr_we_o    = 1'b0;
        csr_wdata_o = '0;
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            if (iss_valid_i[s] && iss_op_i[s] == OP_CSRWR) begin
                csr_we_o    = 1'b1;
                csr_wdata_o = iss_opa_i[s];
            end
        end
    end

    assign csr_waddr_o = iss_csr_addr_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_we_o   <= '0;
            wb_rd_o   <= '0;
            wb_data_o <= '0;
        end else begin
            wb_we_o   <= ex_fwd_we_o;
            wb_rd_o   <= ex_fwd_rd_o;
            wb_data_o <= ex_fwd_data_o;
        end
    end

endmodule

// File: regfile.sv
module regfile (
    input  logic clk,
    input  logic rst_n,

    // Read ports, two per slot: rs1 at 2*slot, rs2 at 2*slot+1
    input  logic [2*dispatch_pkg::ISSUE_WIDTH-1:0][dispatch_pkg::REG_ADDR_W-1:0] raddr_i,
    output logic [2*dispatch_pkg::ISSUE_WIDTH-1:0][dispatch_pkg::XLEN-1:0]       rdata_o,

    // Write ports from writeback
    input  logic [dispatch_pkg::ISSUE_WIDTH-1:0]                           we_i,
    input  logic [dispatch_pkg::ISSUE_WIDTH-1:0][dispatch_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [dispatch_pkg::ISSUE_WIDTH-1:0][dispatch_pkg::XLEN-1:0]       wdata_i
);
    import dispatch_pkg::*;

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    // Later port in the loop wins, so slot 1 takes an equal address
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int w = 0; w < ISSUE_WIDTH; w++) begin
                if (we_i[w] && waddr_i[w] != '0) begin
                    regs[waddr_i[w]] <= wdata_i[w];
                end
            end
        end
    end

    // Old value on a same-cycle write, dispatch forwards around it
    always_comb begin
        for (int p = 0; p < 2*ISSUE_WIDTH; p++) begin
            if (raddr_i[p] == '0) begin
                rdata_o[p] = '0;
            end else begin
                rdata_o[p] = regs[raddr_i[p]];
            end
        end
    end

endmodule

// File: tb_dual_issue.sv
module tb_dual_issue;
    import dispatch_pkg::*;

    localparam int N_DIRECTED    = 18;
    localparam int N_RANDOM      = 24;
    localparam int N_ENTRIES     = N_DIRECTED + N_RANDOM;
    localparam int WATCHDOG_TIME = 40 * (N_ENTRIES * 2 + 20);

    logic clk;
    logic rst_n;
    logic flush_i;
    logic [ISSUE_WIDTH-1:0]                 instr_valid_i;
    op_e  [ISSUE_WIDTH-1:0]                 instr_op_i;
    logic [ISSUE_WIDTH-1:0][REG_ADDR_W-1:0] instr_rd_i;
    logic [ISSUE_WIDTH-1:0][REG_ADDR_W-1:0] instr_rs1_i;
    logic [ISSUE_WIDTH-1:0][REG_ADDR_W-1:0] instr_rs2_i;
    logic [ISSUE_WIDTH-1:0]                 instr_use_imm_i;
    logic [ISSUE_WIDTH-1:0][XLEN-1:0]       instr_imm_i;
    logic [ISSUE_WIDTH-1:0]                 ib_accept_o;
    logic [ISSUE_WIDTH-1:0]                 wb_valid_o;
    logic [ISSUE_WIDTH-1:0][REG_ADDR_W-1:0] wb_rd_o;
    logic [ISSUE_WIDTH-1:0][XLEN-1:0]       wb_data_o;

    // Stimulus table with one entry per instruction in program order
    string                 tbl_name[$];
    op_e                   tbl_op[$];
    logic [REG_ADDR_W-1:0] tbl_rd[$];
    logic [REG_ADDR_W-1:0] tbl_rs1[$];
    logic [REG_ADDR_W-1:0] tbl_rs2[$];
    bit                    tbl_imm_en[$];
    logic [XLEN-1:0]       tbl_imm[$];
    bit                    tbl_pair[$];
    bit                    tbl_flush[$];

    // Expected writebacks for each cycle
    string                                  exp_name[$];
    logic [ISSUE_WIDTH-1:0]                 exp_vld[$];
    logic [ISSUE_WIDTH-1:0][REG_ADDR_W-1:0] exp_rd[$];
    logic [ISSUE_WIDTH-1:0][XLEN-1:0]       exp_data[$];

    logic [XLEN-1:0] arch_reg [32];
    logic [XLEN-1:0] arch_csr [NUM_CSR];

    int                                     idx;
    logic [ISSUE_WIDTH-1:0]                 exp_mask;
    logic [ISSUE_WIDTH-1:0]                 cyc_vld;
    logic [ISSUE_WIDTH-1:0][REG_ADDR_W-1:0] cyc_rd;
    logic [ISSUE_WIDTH-1:0][XLEN-1:0]       cyc_data;

    dual_issue_core DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_TIME);
        report_failure("Timeout: the run did not reach its end in the allowed time");
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_mask(input string name, input logic [ISSUE_WIDTH-1:0] exp,
                              input logic [ISSUE_WIDTH-1:0] act);
        if (act !== exp)
            report_failure($sformatf("ERR %s: expected %b, actual %b", name, exp, act));
    endtask

    task automatic check_rd(input string name, input logic [REG_ADDR_W-1:0] exp,
                            input logic [REG_ADDR_W-1:0] act);
        if (act !== exp)
            report_failure($sformatf("ERR %s: expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic check_data(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
        if (act !== exp)
            report_failure($sformatf("ERR %s: expected %h, actual %h", name, exp, act));
    endtask

    // Pops the oldest expectation and compares it with the writeback outputs
    task automatic check_wb();
        string nm;
        nm = exp_name.pop_front();
        check_mask({nm, " wb_valid"}, exp_vld[0], wb_valid_o);
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            if (exp_vld[0][s]) begin
                check_rd($sformatf("%s wb_rd[%0d]", nm, s), exp_rd[0][s], wb_rd_o[s]);
                check_data($sformatf("%s wb_data[%0d]", nm, s), exp_data[0][s], wb_data_o[s]);
            end
        end
        void'(exp_vld.pop_front());
        void'(exp_rd.pop_front());
        void'(exp_data.pop_front());
    endtask

    task automatic add_entry(input string name, input op_e op, input int rd, input int rs1,
                             input int rs2, input bit imm_en, input logic [XLEN-1:0] imm,
                             input bit pair, input bit flush);
        tbl_name.push_back(name);
        tbl_op.push_back(op);
        tbl_rd.push_back(rd[REG_ADDR_W-1:0]);
        tbl_rs1.push_back(rs1[REG_ADDR_W-1:0]);
        tbl_rs2.push_back(rs2[REG_ADDR_W-1:0]);
        tbl_imm_en.push_back(imm_en);
        tbl_imm.push_back(imm);
        tbl_pair.push_back(pair);
        tbl_flush.push_back(flush);
    endtask

    // No pairing when the younger reads the older rd or either slot is a CSR op
    function automatic bit can_pair(input int i);
        bit raw;
        bit csr;
        if (i + 1 >= tbl_op.size())
            return 1'b0;
        raw = tbl_op[i] != OP_NOP && tbl_rd[i] != 0 &&
              (tbl_rs1[i+1] == tbl_rd[i] || (!tbl_imm_en[i+1] && tbl_rs2[i+1] == tbl_rd[i]));
        csr = tbl_op[i] == OP_CSRRD || tbl_op[i] == OP_CSRWR ||
              tbl_op[i+1] == OP_CSRRD || tbl_op[i+1] == OP_CSRWR;
        return !raw && !csr;
    endfunction

    // Architectural execution of one instruction
    task automatic model_issue(input int i, output bit v, output logic [REG_ADDR_W-1:0] rd,
                               output logic [XLEN-1:0] d);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [1:0]      ca;
        a  = (tbl_rs1[i] == 0) ? '0 : arch_reg[tbl_rs1[i]];
        b  = tbl_imm_en[i] ? tbl_imm[i] : ((tbl_rs2[i] == 0) ? '0 : arch_reg[tbl_rs2[i]]);
        ca = tbl_imm[i][1:0];
        case (tbl_op[i])
            OP_ADD:   d = a + b;
            OP_SUB:   d = a - b;
            OP_AND:   d = a & b;
            OP_OR:    d = a | b;
            OP_XOR:   d = a ^ b;
            OP_SLL:   d = a << b[4:0];
            OP_CSRRD: d = arch_csr[ca];
            OP_CSRWR: begin
                d = arch_csr[ca];
                arch_csr[ca] = a;
            end
            default:  d = '0;
        endcase
        rd = tbl_rd[i];
        v  = tbl_op[i] != OP_NOP && rd != 0;
        if (v)
            arch_reg[rd] = d;
    endtask

    task automatic drive_slot(input int s, input int i);
        instr_valid_i[s]   = 1'b1;
        instr_op_i[s]      = tbl_op[i];
        instr_rd_i[s]      = tbl_rd[i];
        instr_rs1_i[s]     = tbl_rs1[i];
        instr_rs2_i[s]     = tbl_rs2[i];
        instr_use_imm_i[s] = tbl_imm_en[i];
        instr_imm_i[s]     = tbl_imm[i];
    endtask

    task automatic idle_slot(input int s);
        instr_valid_i[s]   = 1'b0;
        instr_op_i[s]      = OP_NOP;
        instr_rd_i[s]      = '0;
        instr_rs1_i[s]     = '0;
        instr_rs2_i[s]     = '0;
        instr_use_imm_i[s] = 1'b0;
        instr_imm_i[s]     = '0;
    endtask

    task automatic push_exp(input string name);
        exp_name.push_back(name);
        exp_vld.push_back(cyc_vld);
        exp_rd.push_back(cyc_rd);
        exp_data.push_back(cyc_data);
    endtask

    task automatic build_table();
        add_entry("pair_indep", OP_ADD,   1,  0,  0, 1, 32'd5,       1, 0);
        add_entry("pair_indep", OP_ADD,   2,  0,  0, 1, 32'd7,       0, 0);
        add_entry("pair_indep", OP_XOR,   3,  1,  2, 0, 32'd0,       1, 0);
        add_entry("pair_indep", OP_SLL,   4,  2,  0, 1, 32'd3,       0, 0);
        add_entry("raw_single", OP_SUB,   5,  4,  1, 0, 32'd0,       0, 0);
        add_entry("fwd_chain",  OP_OR,    6,  5,  0, 0, 32'd0,       0, 0);
        add_entry("fwd_chain",  OP_AND,   7,  5,  6, 0, 32'd0,       1, 0);
        add_entry("fwd_chain",  OP_ADD,   8,  5,  0, 1, 32'd0,       1, 0);
        add_entry("zero_reg",   OP_ADD,   0,  1,  0, 1, 32'd9,       1, 0);
        add_entry("zero_reg",   OP_OR,    9,  0,  0, 0, 32'd0,       1, 0);
        add_entry("csr_rw",     OP_ADD,  10,  0,  0, 1, 32'h1234,    0, 0);
        add_entry("csr_rw",     OP_CSRWR, 11, 10,  0, 1, 32'd2,      0, 0);
        add_entry("csr_rw",     OP_CSRRD, 12,  0,  0, 1, 32'd2,      0, 0);
        add_entry("csr_rw",     OP_CSRWR, 0,  3,  0, 1, 32'd3,       0, 0);
        add_entry("csr_rw",     OP_CSRRD, 13,  0,  0, 1, 32'd3,      0, 0);
        add_entry("csr_rw",     OP_ADD,  14, 13,  0, 1, 32'd1,       0, 0);
        add_entry("flush",      OP_ADD,  15, 14, 11, 0, 32'd0,       1, 1);
        add_entry("flush",      OP_XOR,  16,  1,  2, 0, 32'd0,       0, 0);
        for (int k = 0; k < N_RANDOM; k++) begin
            add_entry("random", op_e'($urandom_range(6, 1)), $urandom_range(7, 0),
                      $urandom_range(7, 0), $urandom_range(7, 0), $urandom_range(1, 0),
                      $urandom(), 0, 0);
        end
        // Flags around the random part follow from the pairing rule
        for (int i = N_DIRECTED - 1; i < N_ENTRIES; i++)
            tbl_pair[i] = can_pair(i);
    endtask

    initial begin
        void'($urandom(32'h42ab_fbb6));
        rst_n     = 1'b0;
        flush_i   = 1'b0;
        for (int s = 0; s < ISSUE_WIDTH; s++)
            idle_slot(s);
        for (int r = 0; r < 32; r++)
            arch_reg[r] = '0;
        for (int c = 0; c < NUM_CSR; c++)
            arch_csr[c] = '0;
        build_table();
        cyc_vld  = '0;
        cyc_rd   = '0;
        cyc_data = '0;
        // Pipeline is empty for the first two cycles
        push_exp("reset");
        push_exp("reset");
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        idx   = 0;
        while (idx < N_ENTRIES) begin
            @(negedge clk);
            check_wb();
            drive_slot(0, idx);
            if (idx + 1 < N_ENTRIES)
                drive_slot(1, idx + 1);
            else
                idle_slot(1);
            flush_i = tbl_flush[idx];
            if (tbl_flush[idx])
                exp_mask = 2'b00;
            else if (tbl_pair[idx])
                exp_mask = 2'b11;
            else
                exp_mask = 2'b01;
            #1;
            check_mask({tbl_name[idx], " accept"}, exp_mask, ib_accept_o);
            cyc_vld  = '0;
            cyc_rd   = '0;
            cyc_data = '0;
            for (int s = 0; s < ISSUE_WIDTH; s++) begin
                if (exp_mask[s])
                    model_issue(idx + s, cyc_vld[s], cyc_rd[s], cyc_data[s]);
            end
            push_exp(tbl_name[idx]);
            tbl_flush[idx] = 1'b0;
            idx += exp_mask[0] + exp_mask[1];
        end
        // Drain the pipeline
        repeat (2) begin
            @(negedge clk);
            check_wb();
            flush_i = 1'b0;
            idle_slot(0);
            idle_slot(1);
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule
